//--- source/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// lines per cache, direct mapped
`define CACHE_SETS 8

// full line width, one cache line
`define LINE_BITS 256

// width of one memory beat
`define BEAT_BITS 64

// beats needed to move one line
`define BURST_BEATS 4

// byte offset inside a line
`define OFFSET_BITS 5

// set index width, log2 of CACHE_SETS
`define INDEX_BITS 3

`endif

//--- source/cache_pkg.sv
package cache_pkg;

    // cache controller states
    // icache never enters WRITEBACK
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL,
        RESPOND
    } cache_state_e;

    // line transfer kind, seen by the arbiter
    typedef enum logic {
        LINE_READ,
        LINE_WRITE
    } line_op_e;

    // which cache holds the memory port
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_ICACHE,
        OWN_DCACHE
    } arb_owner_e;

endpackage

//--- source/icache.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module icache (
    input  logic                  itf,
    input  logic                  rst_n,
    input  logic                  read,
    input  logic [31:0]           address,
    output logic                  resp,
    output logic [31:0]           rdata,
    output logic                  line_req,
    output logic [31:0]           line_addr,
    input  logic                  line_done,
    input  logic [`LINE_BITS-1:0] line_rdata
);
    import cache_pkg::*;

    localparam int TAG_BITS = 32 - `OFFSET_BITS - `INDEX_BITS;

    // tag, data and valid arrays
    logic [TAG_BITS-1:0]    tag_q  [`CACHE_SETS];
    logic [`LINE_BITS-1:0]  data_q [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;

    cache_state_e state_q;
    cache_state_e state_d;

    // address fields
    logic [`INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]     tag_in;
    logic [`OFFSET_BITS-3:0] word_sel;
    logic                    hit;
    logic                    fill_done;

    assign index    = address[`OFFSET_BITS +: `INDEX_BITS];
    assign tag_in   = address[31 -: TAG_BITS];
    // word within the line, bits 4 to 2
    assign word_sel = address[`OFFSET_BITS-1:2];
    assign hit      = valid_q[index] && (tag_q[index] == tag_in);
    // line arrives from the arbiter this cycle
    assign fill_done = (state_q == FILL) && line_done;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // hit skips straight to respond
                if (read) begin
                    state_d = hit ? RESPOND : FILL;
                end
            end
            FILL: begin
                if (line_done) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                // one idle cycle before the next lookup
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fill_done) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // install the refilled line
    always_ff @(posedge itf) begin
        if (fill_done) begin
            tag_q[index]  <= tag_in;
            data_q[index] <= line_rdata;
        end
    end

    // line request held until line_done
    assign line_req  = (state_q == FILL);
    assign line_addr = {address[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    // word read straight out of the array
    assign resp  = (state_q == RESPOND);
    assign rdata = data_q[index][word_sel*32 +: 32];

endmodule

//--- source/dcache.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module dcache (
    input  logic                  itf,
    input  logic                  rst_n,
    input  logic                  read,
    input  logic                  write,
    input  logic [31:0]           address,
    input  logic [3:0]            mbe,
    input  logic [31:0]           wdata,
    output logic                  resp,
    output logic [31:0]           rdata,
    output logic                  line_req,
    output cache_pkg::line_op_e   line_op,
    output logic [31:0]           line_addr,
    output logic [`LINE_BITS-1:0] line_wdata,
    input  logic                  line_done,
    input  logic [`LINE_BITS-1:0] line_rdata
);
    import cache_pkg::*;

    localparam int TAG_BITS = 32 - `OFFSET_BITS - `INDEX_BITS;

    // tag, data, valid and dirty arrays
    logic [TAG_BITS-1:0]    tag_q  [`CACHE_SETS];
    logic [`LINE_BITS-1:0]  data_q [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_SETS-1:0] dirty_q;

    cache_state_e state_q;
    cache_state_e state_d;

    logic [`INDEX_BITS-1:0]  index;
    logic [TAG_BITS-1:0]     tag_in;
    logic [`OFFSET_BITS-3:0] word_sel;
    logic                    hit;
    logic                    write_hit;
    logic                    fill_done;
    logic [`LINE_BITS-1:0]   line_base;
    logic [`LINE_BITS-1:0]   line_merged;

    // overlay the masked bytes of one word onto a line
    function automatic logic [`LINE_BITS-1:0] merge_word(
        input logic [`LINE_BITS-1:0]  line,
        input logic [`OFFSET_BITS-3:0] sel,
        input logic [3:0]              be,
        input logic [31:0]             word
    );
        logic [`LINE_BITS-1:0] result;
        result = line;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[sel*32 + b*8 +: 8] = word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign index     = address[`OFFSET_BITS +: `INDEX_BITS];
    assign tag_in    = address[31 -: TAG_BITS];
    assign word_sel  = address[`OFFSET_BITS-1:2];
    assign hit       = valid_q[index] && (tag_q[index] == tag_in);
    assign write_hit = (state_q == IDLE) && write && hit;
    assign fill_done = (state_q == FILL) && line_done;

    // refill line or resident line, then the store on top
    assign line_base   = (state_q == FILL) ? line_rdata : data_q[index];
    assign line_merged = merge_word(line_base, word_sel, mbe, wdata);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (read || write) begin
                    if (hit) begin
                        state_d = RESPOND;
                    end else if (valid_q[index] && dirty_q[index]) begin
                        // victim must go out first
                        state_d = WRITEBACK;
                    end else begin
                        state_d = FILL;
                    end
                end
            end
            WRITEBACK: begin
                if (line_done) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (line_done) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (write_hit) begin
                dirty_q[index] <= 1'b1;
            end else if (fill_done) begin
                valid_q[index] <= 1'b1;
                // fresh line is dirty only when a store lands in it
                dirty_q[index] <= write;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (write_hit || fill_done) begin
            data_q[index] <= write ? line_merged : line_base;
        end
        if (fill_done) begin
            tag_q[index] <= tag_in;
        end
    end

    // writeback uses the victim address, fill the request address
    assign line_req   = (state_q == WRITEBACK) || (state_q == FILL);
    assign line_op    = (state_q == WRITEBACK) ? LINE_WRITE : LINE_READ;
    assign line_addr  = (state_q == WRITEBACK) ?
                        {tag_q[index], index, {`OFFSET_BITS{1'b0}}} :
                        {address[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    assign line_wdata = data_q[index];

    assign resp  = (state_q == RESPOND);
    assign rdata = data_q[index][word_sel*32 +: 32];

endmodule

//--- source/line_burst_arbiter.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module line_burst_arbiter (
    input  logic                  itf,
    input  logic                  rst_n,
    // instruction side, reads only
    input  logic                  i_req,
    input  logic [31:0]           i_addr,
    output logic                  i_done,
    output logic [`LINE_BITS-1:0] i_rdata,
    // data side
    input  logic                  d_req,
    input  cache_pkg::line_op_e   d_op,
    input  logic [31:0]           d_addr,
    input  logic [`LINE_BITS-1:0] d_wdata,
    output logic                  d_done,
    output logic [`LINE_BITS-1:0] d_rdata,
    // burst memory port
    output logic [`BEAT_BITS-1:0] burst_o,
    input  logic [`BEAT_BITS-1:0] burst_i,
    output logic [31:0]           address_o,
    output logic                  read_o,
    output logic                  write_o,
    input  logic                  resp_i
);
    import cache_pkg::*;

    arb_owner_e            owner_q;
    line_op_e              op_q;
    logic [31:0]           addr_q;
    // assembles read beats, emits write beats
    logic [`LINE_BITS-1:0] shift_q;
    logic [1:0]            beat_q;
    logic                  done_q;

    logic                  active;
    logic                  last_beat;
    logic [`BEAT_BITS-1:0] beat_in;

    // burst in flight, done cycle excluded
    assign active    = (owner_q != OWN_NONE) && !done_q;
    assign last_beat = resp_i && (beat_q == 2'(`BURST_BEATS - 1));
    // write bursts shift in zeros behind the outgoing beats
    assign beat_in   = (op_q == LINE_READ) ? burst_i : '0;

    // grant, beat count and done pulse
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            owner_q <= OWN_NONE;
            beat_q  <= '0;
            done_q  <= 1'b0;
        end else if (owner_q == OWN_NONE) begin
            // data side wins a tie
            if (d_req) begin
                owner_q <= OWN_DCACHE;
            end else if (i_req) begin
                owner_q <= OWN_ICACHE;
            end
            beat_q <= '0;
        end else if (done_q) begin
            // release after the done pulse, requester has dropped by now
            owner_q <= OWN_NONE;
            done_q  <= 1'b0;
        end else if (resp_i) begin
            beat_q <= beat_q + 2'd1;
            done_q <= last_beat;
        end
    end

    // latch the winner's request, then shift one beat per resp_i
    always_ff @(posedge itf) begin
        if (owner_q == OWN_NONE) begin
            if (d_req) begin
                op_q    <= d_op;
                addr_q  <= d_addr;
                shift_q <= d_wdata;
            end else if (i_req) begin
                op_q   <= LINE_READ;
                addr_q <= i_addr;
            end
        end else if (active && resp_i) begin
            // low beat first
            shift_q <= {beat_in, shift_q[`LINE_BITS-1:`BEAT_BITS]};
        end
    end

    assign read_o    = active && (op_q == LINE_READ);
    assign write_o   = active && (op_q == LINE_WRITE);
    assign address_o = addr_q;
    assign burst_o   = shift_q[`BEAT_BITS-1:0];

    // shared line, only the owner sees done
    assign i_done  = done_q && (owner_q == OWN_ICACHE);
    assign d_done  = done_q && (owner_q == OWN_DCACHE);
    assign i_rdata = shift_q;
    assign d_rdata = shift_q;

endmodule

//--- source/cache_subsystem.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_subsystem (
    input  logic                  itf,
    input  logic                  rst_n,
    input  logic                  icache_read,
    input  logic [31:0]           icache_address,
    output logic                  icache_resp,
    output logic [31:0]           icache_rdata,
    input  logic                  dcache_read,
    input  logic                  dcache_write,
    input  logic [31:0]           dcache_address,
    input  logic [3:0]            dcache_mbe,
    input  logic [31:0]           dcache_wdata,
    output logic                  dcache_resp,
    output logic [31:0]           dcache_rdata,
    output logic [`BEAT_BITS-1:0] burst_o,
    input  logic [`BEAT_BITS-1:0] burst_i,
    output logic [31:0]           address_o,
    output logic                  read_o,
    output logic                  write_o,
    input  logic                  resp_i
);
    import cache_pkg::*;

    // icache line port
    logic                  i_line_req;
    logic [31:0]           i_line_addr;
    logic                  i_line_done;
    logic [`LINE_BITS-1:0] i_line_rdata;

    // dcache line port
    logic                  d_line_req;
    line_op_e              d_line_op;
    logic [31:0]           d_line_addr;
    logic [`LINE_BITS-1:0] d_line_wdata;
    logic                  d_line_done;
    logic [`LINE_BITS-1:0] d_line_rdata;

    icache icache_inst (
        .itf(itf), .rst_n(rst_n),
        .read(icache_read), .address(icache_address),
        .resp(icache_resp), .rdata(icache_rdata),
        .line_req(i_line_req), .line_addr(i_line_addr),
        .line_done(i_line_done), .line_rdata(i_line_rdata)
    );

    dcache dcache_inst (
        .itf(itf), .rst_n(rst_n),
        .read(dcache_read), .write(dcache_write), .address(dcache_address),
        .mbe(dcache_mbe), .wdata(dcache_wdata),
        .resp(dcache_resp), .rdata(dcache_rdata),
        .line_req(d_line_req), .line_op(d_line_op), .line_addr(d_line_addr),
        .line_wdata(d_line_wdata), .line_done(d_line_done), .line_rdata(d_line_rdata)
    );

    // one burst port shared by both caches
    line_burst_arbiter arbiter_inst (
        .itf(itf), .rst_n(rst_n),
        .i_req(i_line_req), .i_addr(i_line_addr),
        .i_done(i_line_done), .i_rdata(i_line_rdata),
        .d_req(d_line_req), .d_op(d_line_op), .d_addr(d_line_addr),
        .d_wdata(d_line_wdata), .d_done(d_line_done), .d_rdata(d_line_rdata),
        .burst_o(burst_o), .burst_i(burst_i), .address_o(address_o),
        .read_o(read_o), .write_o(write_o), .resp_i(resp_i)
    );

endmodule

//--- tests/cache_subsystem_assertions.sv
`timescale 1ns/1ns

module cache_subsystem_assertions (
    input logic        itf,
    input logic        rst_n,
    input logic        read_o,
    input logic        write_o,
    input logic [31:0] address_o,
    input logic        i_done,
    input logic        d_done
);
    // count of failed assertions
    int unsigned failures = 0;

    // one direction per burst
    one_direction: assert property (@(posedge itf) disable iff (!rst_n)
        !(read_o && write_o))
        else begin
            $error("read_o and write_o high together");
            failures++;
        end

    // bursts always start on a line boundary
    line_aligned: assert property (@(posedge itf) disable iff (!rst_n)
        (read_o || write_o) |-> (address_o[4:0] == 5'd0))
        else begin
            $error("address_o not line aligned during a burst");
            failures++;
        end

    // address held for the whole burst
    address_held: assert property (@(posedge itf) disable iff (!rst_n)
        (read_o || write_o) |=> (!(read_o || write_o) || $stable(address_o)))
        else begin
            $error("address_o changed inside a burst");
            failures++;
        end

    // only the owner gets a done pulse
    single_done: assert property (@(posedge itf) disable iff (!rst_n)
        !(i_done && d_done))
        else begin
            $error("i_done and d_done pulsed together");
            failures++;
        end

endmodule

//--- tests/cache_subsystem_tb.sv
`timescale 1ns/1ns

`include "cache_cfg.svh"

module cache_subsystem_tb;

    localparam int READ_OPS  = 60;
    localparam int WRITE_OPS = 60;
    localparam int MIXED_OPS = 80;
    // every core request of every test, setup reads included
    localparam int TOTAL_OPS = 2 * READ_OPS + 2 * WRITE_OPS + 3 + 4 + MIXED_OPS;
    // two bursts at up to 3 + 7 cycles each, plus a wait behind the other cache
    localparam int CYCLES_PER_OP = 60;
    localparam int CYCLE_LIMIT   = 10 + TOTAL_OPS * CYCLES_PER_OP;

    logic                  itf = 1'b0;
    logic                  rst_n;
    logic                  icache_read;
    logic [31:0]           icache_address;
    logic                  icache_resp;
    logic [31:0]           icache_rdata;
    logic                  dcache_read;
    logic                  dcache_write;
    logic [31:0]           dcache_address;
    logic [3:0]            dcache_mbe;
    logic [31:0]           dcache_wdata;
    logic                  dcache_resp;
    logic [31:0]           dcache_rdata;
    logic [`BEAT_BITS-1:0] burst_o;
    logic [`BEAT_BITS-1:0] burst_i;
    logic [31:0]           address_o;
    logic                  read_o;
    logic                  write_o;
    logic                  resp_i;

    // burst memory and the write-through reference
    logic [7:0]  mem     [4096];
    logic [7:0]  ref_mem [4096];
    // line address of every burst, in start order
    logic [31:0] burst_log [$];
    logic [31:0] lfsr_state = 32'd4229;
    int          checks = 0;
    int          fails = 0;
    int          mark_checks = 0;
    int          mark_fails = 0;
    int          cycle_count = 0;

    cache_subsystem DUT (.*);

    bind line_burst_arbiter cache_subsystem_assertions protocol_checks (
        .itf(itf), .rst_n(rst_n), .read_o(read_o), .write_o(write_o),
        .address_o(address_o), .i_done(i_done), .d_done(d_done)
    );

    always #4 itf = ~itf;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // little endian word views of both arrays
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        int a;
        a = int'(addr[11:0]);
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        int a;
        a = int'(addr[11:0]);
        return {mem[a + 3], mem[a + 2], mem[a + 1], mem[a]};
    endfunction

    // store applied at once, masked bytes only
    function automatic void ref_write(input logic [31:0] addr, input logic [3:0] be,
                                      input logic [31:0] wdata);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[int'(addr[11:0]) + b] = wdata[b*8 +: 8];
            end
        end
    endfunction

    // inputs change 1 ns after the edge, outputs are settled there too
    task automatic next_cycle();
        @(posedge itf);
        #1;
    endtask

    task automatic check_word(input string name, input logic [31:0] addr,
                              input logic [31:0] got, input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("Error: %s at %h read %h, expected %h", name, addr, got, expected);
            fails++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            fails++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d failed", name, checks - mark_checks, fails - mark_fails);
        mark_checks = checks;
        mark_fails  = fails;
    endtask

    // hold the read until resp, then one idle cycle
    task automatic fetch(input logic [31:0] addr, output logic [31:0] data,
                         output int cycles);
        icache_read    = 1'b1;
        icache_address = addr;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!icache_resp);
        data = icache_rdata;
        icache_read = 1'b0;
        next_cycle();
    endtask

    task automatic data_access(input logic is_write, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata,
                               output logic [31:0] data);
        dcache_read    = !is_write;
        dcache_write   = is_write;
        dcache_address = addr;
        dcache_mbe     = be;
        dcache_wdata   = wdata;
        if (is_write) begin
            ref_write(addr, be, wdata);
        end
        do begin
            next_cycle();
        end while (!dcache_resp);
        data = dcache_rdata;
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
        next_cycle();
    endtask

    // random start delay, then four beats with optional gaps
    task automatic serve_burst();
        int   base;
        int   gap;
        logic is_write;
        base     = int'(address_o[11:0]);
        is_write = write_o;
        burst_log.push_back(address_o);
        gap = int'(lfsr_bits(2));
        repeat (gap) next_cycle();
        for (int beat = 0; beat < `BURST_BEATS; beat++) begin
            if (beat > 0 && lfsr_bits(1) == 1) begin
                resp_i = 1'b0;
                next_cycle();
            end
            resp_i = 1'b1;
            for (int b = 0; b < 8; b++) begin
                if (is_write) begin
                    mem[base + beat*8 + b] = burst_o[b*8 +: 8];
                end else begin
                    burst_i[b*8 +: 8] = mem[base + beat*8 + b];
                end
            end
            next_cycle();
        end
        resp_i = 1'b0;
    endtask

    initial begin : memory_model
        resp_i  = 1'b0;
        burst_i = '0;
        forever begin
            next_cycle();
            if (rst_n && (read_o || write_o)) begin
                serve_burst();
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge itf);
            cycle_count++;
        end
        $display("timeout, a request was still unanswered after %0d cycles", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] other;
        logic [31:0] daddr;
        logic [31:0] word;
        logic [31:0] dword;
        logic [31:0] wdata;
        logic [3:0]  be;
        int          cycles;
        int          first;
        int          total_fails;
        logic        icache_seen;
        rst_n          = 1'b0;
        icache_read    = 1'b0;
        icache_address = '0;
        dcache_read    = 1'b0;
        dcache_write   = 1'b0;
        dcache_address = '0;
        dcache_mbe     = '0;
        dcache_wdata   = '0;
        // instructions below 0x800, data above
        for (int a = 0; a < 4096; a++) begin
            mem[a]     = 8'(lfsr_bits(8));
            ref_mem[a] = mem[a];
        end
        repeat (10) @(posedge itf);
        #1;
        rst_n = 1'b1;

        // second read of each address must hit
        for (int n = 0; n < READ_OPS; n++) begin
            addr = lfsr_bits(9) << 2;
            fetch(addr, word, cycles);
            check_word("icache_rdata", addr, word, ref_word(addr));
            fetch(addr, word, cycles);
            check_word("icache_rdata", addr, word, ref_word(addr));
            check_true(cycles == 1, $sformatf("icache hit at %h answered after %0d cycles",
                                              addr, cycles));
        end
        finish_test("test 1 instruction reads");

        for (int n = 0; n < WRITE_OPS; n++) begin
            addr  = 32'h800 | (lfsr_bits(9) << 2);
            be    = 4'(lfsr_bits(4));
            wdata = lfsr_bits(32);
            data_access(1'b1, addr, be, wdata, word);
            data_access(1'b0, addr, 4'h0, 32'h0, word);
            check_word("dcache_rdata", addr, word, ref_word(addr));
        end
        finish_test("test 2 byte-enable writes");

        // flip tag bit 8, same index
        addr  = 32'h800 | (lfsr_bits(9) << 2);
        other = addr ^ 32'h100;
        wdata = lfsr_bits(32);
        data_access(1'b1, addr, 4'hf, wdata, word);
        data_access(1'b0, other, 4'h0, 32'h0, word);
        check_word("dcache_rdata", other, word, ref_word(other));
        // written-back line must match the reference
        for (int w = 0; w < 8; w++) begin
            check_word("memory line", {addr[31:5], 5'd0} + 4 * w,
                       mem_word({addr[31:5], 5'd0} + 4 * w),
                       ref_word({addr[31:5], 5'd0} + 4 * w));
        end
        data_access(1'b0, addr, 4'h0, 32'h0, word);
        check_word("dcache_rdata", addr, word, ref_word(addr));
        finish_test("test 3 eviction writeback");

        // park other lines in both target sets so both requests miss
        addr  = lfsr_bits(9) << 2;
        daddr = 32'h800 | (lfsr_bits(9) << 2);
        fetch(addr ^ 32'h100, word, cycles);
        data_access(1'b0, daddr ^ 32'h100, 4'h0, 32'h0, dword);
        first = burst_log.size();
        fork
            fetch(addr, word, cycles);
            data_access(1'b0, daddr, 4'h0, 32'h0, dword);
        join
        check_word("icache_rdata", addr, word, ref_word(addr));
        check_word("dcache_rdata", daddr, dword, ref_word(daddr));
        check_true(burst_log.size() > first && burst_log[first] >= 32'h800,
                   "first burst after the tie did not come from the data cache");
        icache_seen = 1'b0;
        for (int k = first + 1; k < burst_log.size(); k++) begin
            if (burst_log[k] == {addr[31:5], 5'd0}) begin
                icache_seen = 1'b1;
            end
        end
        check_true(icache_seen, "instruction fill burst missing after the data burst");
        finish_test("test 4 side-by-side requests");

        // data side squeezed into 16 lines for conflicts
        fork
            begin
                logic [31:0] iaddr;
                logic [31:0] iword;
                int          icycles;
                for (int n = 0; n < MIXED_OPS / 2; n++) begin
                    iaddr = lfsr_bits(9) << 2;
                    fetch(iaddr, iword, icycles);
                    check_word("icache_rdata", iaddr, iword, ref_word(iaddr));
                end
            end
            begin
                logic [31:0] maddr;
                logic [31:0] mword;
                for (int n = 0; n < MIXED_OPS / 2; n++) begin
                    maddr = 32'h800 | (lfsr_bits(4) << 5) | (lfsr_bits(3) << 2);
                    if (lfsr_bits(1) == 1) begin
                        data_access(1'b1, maddr, 4'(lfsr_bits(4)), lfsr_bits(32), mword);
                    end else begin
                        data_access(1'b0, maddr, 4'h0, 32'h0, mword);
                        check_word("dcache_rdata", maddr, mword, ref_word(maddr));
                    end
                end
            end
        join
        finish_test("test 5 mixed traffic");

        total_fails = fails + int'(DUT.arbiter_inst.protocol_checks.failures);
        $display("total: %0d checks, %0d failed, %0d protocol assertion failures",
                 checks, fails, DUT.arbiter_inst.protocol_checks.failures);
        if (total_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- cache_subsystem.f
+incdir+source
source/cache_pkg.sv
source/icache.sv
source/dcache.sv
source/line_burst_arbiter.sv
source/cache_subsystem.sv
tests/cache_subsystem_assertions.sv
tests/cache_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cache subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_subsystem_tb -Mdir obj_dir -f cache_subsystem.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcache_subsystem_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "simulation reported failures"
exit 1
